// File: common/streamer_macros.svh
// Streamer widths and depths shared by every RTL block
`ifndef STREAMER_MACROS_SVH
`define STREAMER_MACROS_SVH

`default_nettype none

// Memory data word width in bits
// Also the width of one X or Z stream beat
`define STREAMER_DW 32

// Byte address width of the Wishbone port
`define STREAMER_AW 32

// Width of the word-count fields on the control ports
`define STREAMER_LW 16

// Number of words the load channel can hold ahead of the X stream
// Keep this a power of two so the buffer pointers wrap on their own
`define LD_BUF_DEPTH 2

`default_nettype wire

`endif

// File: common/streamer_pkg.sv
// Streamer shared types for memory words seen as FP32 or as FP16 pairs
`include "streamer_macros.svh"

`default_nettype none

package streamer_pkg;

  // One memory word with two views of the same bits
  // fp32 is the whole word as one single precision value
  // half[0] is bits 15:0, half[1] is bits 31:16
  // Load widens half[0] first, store fills half[0] first
  typedef union packed {
    logic [`STREAMER_DW-1:0]             fp32;
    logic [1:0][`STREAMER_DW/2-1:0]      half;
  } mem_word_u;

endpackage

`default_nettype wire

// File: load/cast_in.sv
// FP16 to FP32 widening of one half-word, denormals flushed to zero
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module cast_in
  import streamer_pkg::*;
(
  input  wire logic [`STREAMER_DW/2-1:0] half_i,
  output mem_word_u                      word_o
);

  // Source fields of the half precision value
  logic       sign;
  logic [4:0] exp_h;
  logic [9:0] man_h;

  assign sign  = half_i[15];
  assign exp_h = half_i[14:10];
  assign man_h = half_i[9:0];

  always_comb begin
    if (exp_h == 5'd0) begin
      // Zero and denormals both end up as signed zero
      word_o.fp32 = {sign, 31'd0};
    end else if (exp_h == 5'd31) begin
      // Infinity and NaN keep their payload in the top mantissa bits
      word_o.fp32 = {sign, 8'hff, man_h, 13'd0};
    end else begin
      // Normal number, bias 15 becomes bias 127
      word_o.fp32 = {sign, {3'd0, exp_h} + 8'd112, man_h, 13'd0};
    end
  end

endmodule

`default_nettype wire

// File: load/load_channel.sv
// Load channel: read requests, word buffer and X stream beat emission
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module load_channel
  import streamer_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   start_i,
  input  wire logic [`STREAMER_AW-1:0] base_i,
  input  wire logic [`STREAMER_LW-1:0] words_i,
  input  wire logic                   cast_en_i,
  input  wire logic                   req_ack_i,
  input  wire logic [`STREAMER_DW-1:0] req_rdata_i,
  input  wire logic                   x_ready_i,
  output logic                        req_o,
  output logic [`STREAMER_AW-1:0]     req_adr_o,
  output logic                        x_valid_o,
  output logic [`STREAMER_DW-1:0]     x_data_o,
  output logic                        busy_o,
  output logic                        done_o
);

  // Job state
  logic                    busy_q;
  logic                    done_q;
  logic                    cast_q;
  logic [`STREAMER_LW-1:0] words_q;
  logic [`STREAMER_AW-1:0] adr_q;
  // Words read from memory and words fully emitted on X
  logic [`STREAMER_LW-1:0] req_cnt_q;
  logic [`STREAMER_LW-1:0] emit_cnt_q;
  // Word buffer, pointers wrap because the depth is a power of two
  logic [`STREAMER_DW-1:0]             buf_q [`LD_BUF_DEPTH];
  logic [$clog2(`LD_BUF_DEPTH)-1:0]    wr_ptr_q;
  logic [$clog2(`LD_BUF_DEPTH)-1:0]    rd_ptr_q;
  logic [$clog2(`LD_BUF_DEPTH+1)-1:0]  used_q;
  // High half of the head word is next when set
  logic                    half_sel_q;

  mem_word_u head;
  mem_word_u wide_lo;
  mem_word_u wide_hi;
  logic      x_hs;
  logic      pop;
  logic      start;

  assign start = start_i & ~busy_q;

  // One read in flight at most, so a free entry is all that is needed
  assign req_o     = busy_q & (req_cnt_q != words_q) & (used_q != `LD_BUF_DEPTH);
  assign req_adr_o = adr_q;

  assign head = buf_q[rd_ptr_q];

  cast_in u_cast_lo (
    .half_i (head.half[0]),
    .word_o (wide_lo)
  );

  cast_in u_cast_hi (
    .half_i (head.half[1]),
    .word_o (wide_hi)
  );

  // Buffer is empty outside a job
  assign x_valid_o = (used_q != '0);
  assign x_data_o  = cast_q ? (half_sel_q ? wide_hi.fp32 : wide_lo.fp32) : head.fp32;
  assign x_hs      = x_valid_o & x_ready_i;
  // Word leaves the buffer on its last beat
  assign pop       = x_hs & (~cast_q | half_sel_q);

  assign busy_o = busy_q;
  assign done_o = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      cast_q     <= 1'b0;
      words_q    <= '0;
      adr_q      <= '0;
      req_cnt_q  <= '0;
      emit_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      used_q     <= '0;
      half_sel_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        // Empty job finishes at once
        busy_q     <= (words_i != '0);
        done_q     <= (words_i == '0);
        cast_q     <= cast_en_i;
        words_q    <= words_i;
        adr_q      <= base_i;
        req_cnt_q  <= '0;
        emit_cnt_q <= '0;
        half_sel_q <= 1'b0;
      end
      // Read returns, next word address
      if (req_ack_i) begin
        req_cnt_q <= req_cnt_q + 1'b1;
        adr_q     <= adr_q + `STREAMER_AW'd4;
        wr_ptr_q  <= wr_ptr_q + 1'b1;
      end
      if (x_hs && cast_q) begin
        half_sel_q <= ~half_sel_q;
      end
      if (pop) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        emit_cnt_q <= emit_cnt_q + 1'b1;
        // Last beat of the job
        if (emit_cnt_q + 1'b1 == words_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
      // Fill level follows writes and pops
      if (req_ack_i && !pop) begin
        used_q <= used_q + 1'b1;
      end else if (!req_ack_i && pop) begin
        used_q <= used_q - 1'b1;
      end
    end
  end

  // Word is captured in the ack cycle
  always_ff @(posedge clk_i) begin
    if (req_ack_i) begin
      buf_q[wr_ptr_q] <= req_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: store/cast_out.sv
// FP32 to FP16 narrowing with truncation toward zero
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module cast_out
  import streamer_pkg::*;
(
  input  wire mem_word_u            word_i,
  output logic [`STREAMER_DW/2-1:0] half_o
);

  // Source fields of the single precision value
  logic              sign;
  logic [7:0]        exp_s;
  logic [22:0]       man_s;
  // Exponent moved to bias 15, may go negative
  logic signed [9:0] exp_rb;
  // Mantissa bits kept after truncation
  logic [9:0]        man_k;

  assign sign   = word_i.fp32[31];
  assign exp_s  = word_i.fp32[30:23];
  assign man_s  = word_i.fp32[22:0];
  assign exp_rb = $signed({2'b00, exp_s}) - 10'sd112;
  assign man_k  = man_s[22:13];

  always_comb begin
    if (exp_s == 8'hff) begin
      // NaN whose payload sits only in the low bits must stay a NaN
      if ((man_s != '0) && (man_k == '0)) begin
        half_o = {sign, 5'h1f, 1'b1, man_k[8:0]};
      end else begin
        half_o = {sign, 5'h1f, man_k};
      end
    end else if (exp_rb <= 10'sd0) begin
      // Underflow, no denormals on the FP16 side
      half_o = {sign, 15'd0};
    end else if (exp_rb >= 10'sd31) begin
      // Overflow saturates to infinity
      half_o = {sign, 5'h1f, 10'd0};
    end else begin
      half_o = {sign, exp_rb[4:0], man_k};
    end
  end

endmodule

`default_nettype wire

// File: store/store_channel.sv
// Store channel: Z stream beat collection, word packing and write requests
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module store_channel
  import streamer_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   start_i,
  input  wire logic [`STREAMER_AW-1:0] base_i,
  input  wire logic [`STREAMER_LW-1:0] words_i,
  input  wire logic                   cast_en_i,
  input  wire logic                   z_valid_i,
  input  wire logic [`STREAMER_DW-1:0] z_data_i,
  input  wire logic                   req_ack_i,
  output logic                        z_ready_o,
  output logic                        req_o,
  output logic [`STREAMER_AW-1:0]     req_adr_o,
  output logic [`STREAMER_DW-1:0]     req_wdata_o,
  output logic                        busy_o,
  output logic                        done_o
);

  // Job state
  logic                    busy_q;
  logic                    done_q;
  logic                    cast_q;
  logic [`STREAMER_LW-1:0] words_q;
  logic [`STREAMER_AW-1:0] adr_q;
  // Words acked by memory so far
  logic [`STREAMER_LW-1:0] word_cnt_q;
  // Packed word and its pending write
  mem_word_u               pack_q;
  logic                    req_q;
  // Next narrowed beat goes to half 1 when set
  logic                    half_q;

  logic [`STREAMER_DW/2-1:0] narrow;
  logic                      z_hs;
  logic                      start;

  assign start = start_i & ~busy_q;

  cast_out u_cast (
    .word_i (z_data_i),
    .half_o (narrow)
  );

  // No beats while a packed word waits for memory
  assign z_ready_o = busy_q & ~req_q;
  assign z_hs      = z_valid_i & z_ready_o;

  assign req_o       = req_q;
  assign req_adr_o   = adr_q;
  assign req_wdata_o = pack_q.fp32;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      cast_q     <= 1'b0;
      words_q    <= '0;
      adr_q      <= '0;
      word_cnt_q <= '0;
      req_q      <= 1'b0;
      half_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q     <= (words_i != '0);
        done_q     <= (words_i == '0);
        cast_q     <= cast_en_i;
        words_q    <= words_i;
        adr_q      <= base_i;
        word_cnt_q <= '0;
        half_q     <= 1'b0;
      end
      // Word complete after one plain beat or two narrowed beats
      if (z_hs) begin
        if (cast_q) begin
          half_q <= ~half_q;
          req_q  <= half_q;
        end else begin
          req_q <= 1'b1;
        end
      end
      if (req_ack_i) begin
        req_q      <= 1'b0;
        adr_q      <= adr_q + `STREAMER_AW'd4;
        word_cnt_q <= word_cnt_q + 1'b1;
        // Done follows the ack of the last word
        if (word_cnt_q + 1'b1 == words_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Payload register, low half filled first under cast
  always_ff @(posedge clk_i) begin
    if (z_hs) begin
      if (!cast_q) begin
        pack_q.fp32 <= z_data_i;
      end else if (half_q) begin
        pack_q.half[1] <= narrow;
      end else begin
        pack_q.half[0] <= narrow;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ldst_arbiter.sv
// Round-robin merge of load and store requests onto a Wishbone classic master
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module ldst_arbiter (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    ld_req_i,
  input  wire logic [`STREAMER_AW-1:0] ld_adr_i,
  input  wire logic                    st_req_i,
  input  wire logic [`STREAMER_AW-1:0] st_adr_i,
  input  wire logic [`STREAMER_DW-1:0] st_wdata_i,
  input  wire logic [`STREAMER_DW-1:0] wb_dat_i,
  input  wire logic                    wb_ack_i,
  output logic                         ld_ack_o,
  output logic [`STREAMER_DW-1:0]      ld_rdata_o,
  output logic                         st_ack_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [`STREAMER_AW-1:0]      wb_adr_o,
  output logic [`STREAMER_DW/8-1:0]    wb_sel_o,
  output logic [`STREAMER_DW-1:0]      wb_dat_o
);

  // FSM as two flags, both low is idle
  logic active_q;
  logic release_q;
  // Granted channel and last served channel, set means store
  logic gnt_st_q;
  logic last_st_q;
  logic pick_st;

  // Store wins unless load also asks and store went last
  assign pick_st = st_req_i & (~ld_req_i | ~last_st_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q  <= 1'b0;
      release_q <= 1'b0;
      gnt_st_q  <= 1'b0;
      last_st_q <= 1'b0;
    end else if (release_q) begin
      release_q <= 1'b0;
    end else if (active_q) begin
      if (wb_ack_i) begin
        active_q  <= 1'b0;
        release_q <= 1'b1;
        last_st_q <= gnt_st_q;
      end
    end else if (ld_req_i || st_req_i) begin
      active_q <= 1'b1;
      gnt_st_q <= pick_st;
    end
  end

  // Channels hold address and data until their ack
  assign wb_cyc_o = active_q;
  assign wb_stb_o = active_q;
  assign wb_we_o  = gnt_st_q;
  assign wb_adr_o = gnt_st_q ? st_adr_i : ld_adr_i;
  assign wb_dat_o = st_wdata_i;
  assign wb_sel_o = '1;

  assign ld_ack_o   = wb_ack_i & active_q & ~gnt_st_q;
  assign st_ack_o   = wb_ack_i & active_q & gnt_st_q;
  assign ld_rdata_o = wb_dat_i;

endmodule

`default_nettype wire

// File: rtl/streamer_top.sv
// Streamer top: load and store channels sharing one Wishbone master port
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module streamer_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    cast_en_i,
  input  wire logic                    ld_start_i,
  input  wire logic [`STREAMER_AW-1:0] ld_base_i,
  input  wire logic [`STREAMER_LW-1:0] ld_words_i,
  input  wire logic                    st_start_i,
  input  wire logic [`STREAMER_AW-1:0] st_base_i,
  input  wire logic [`STREAMER_LW-1:0] st_words_i,
  input  wire logic                    x_ready_i,
  input  wire logic                    z_valid_i,
  input  wire logic [`STREAMER_DW-1:0] z_data_i,
  input  wire logic [`STREAMER_DW-1:0] wb_dat_i,
  input  wire logic                    wb_ack_i,
  output logic                         x_valid_o,
  output logic [`STREAMER_DW-1:0]      x_data_o,
  output logic                         z_ready_o,
  output logic                         ld_busy_o,
  output logic                         st_busy_o,
  output logic                         ld_done_o,
  output logic                         st_done_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [`STREAMER_AW-1:0]      wb_adr_o,
  output logic [`STREAMER_DW/8-1:0]    wb_sel_o,
  output logic [`STREAMER_DW-1:0]      wb_dat_o
);

  // Load side request port
  logic                    ld_req;
  logic [`STREAMER_AW-1:0] ld_adr;
  logic                    ld_ack;
  logic [`STREAMER_DW-1:0] ld_rdata;
  // Store side request port
  logic                    st_req;
  logic [`STREAMER_AW-1:0] st_adr;
  logic [`STREAMER_DW-1:0] st_wdata;
  logic                    st_ack;

  load_channel u_load (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (ld_start_i),
    .base_i      (ld_base_i),
    .words_i     (ld_words_i),
    .cast_en_i   (cast_en_i),
    .req_ack_i   (ld_ack),
    .req_rdata_i (ld_rdata),
    .x_ready_i   (x_ready_i),
    .req_o       (ld_req),
    .req_adr_o   (ld_adr),
    .x_valid_o   (x_valid_o),
    .x_data_o    (x_data_o),
    .busy_o      (ld_busy_o),
    .done_o      (ld_done_o)
  );

  store_channel u_store (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (st_start_i),
    .base_i      (st_base_i),
    .words_i     (st_words_i),
    .cast_en_i   (cast_en_i),
    .z_valid_i   (z_valid_i),
    .z_data_i    (z_data_i),
    .req_ack_i   (st_ack),
    .z_ready_o   (z_ready_o),
    .req_o       (st_req),
    .req_adr_o   (st_adr),
    .req_wdata_o (st_wdata),
    .busy_o      (st_busy_o),
    .done_o      (st_done_o)
  );

  // Both channels meet on the one Wishbone port here
  ldst_arbiter u_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ld_req_i   (ld_req),
    .ld_adr_i   (ld_adr),
    .st_req_i   (st_req),
    .st_adr_i   (st_adr),
    .st_wdata_i (st_wdata),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .ld_ack_o   (ld_ack),
    .ld_rdata_o (ld_rdata),
    .st_ack_o   (st_ack),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_sel_o   (wb_sel_o),
    .wb_dat_o   (wb_dat_o)
  );

endmodule

`default_nettype wire

// File: tests/streamer_sva.sv
// Wishbone master protocol assertions bound to the load/store arbiter
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module streamer_sva (
  input wire logic                    clk_i,
  input wire logic                    rst_n_i,
  input wire logic                    wb_cyc_o,
  input wire logic                    wb_stb_o,
  input wire logic                    wb_we_o,
  input wire logic [`STREAMER_AW-1:0] wb_adr_o,
  input wire logic [`STREAMER_DW-1:0] wb_dat_o,
  input wire logic                    wb_ack_i
);

  // Write data held until the slave answers
  a_wdat_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_stb_o && wb_we_o && !wb_ack_i) |=> $stable(wb_dat_o))
    else $error("wb_dat_o changed before wb_ack_i on a write");

  // Address held until the slave answers
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
    else $error("wb_adr_o changed before wb_ack_i");

  // One release cycle after every ack
  a_stb_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_stb_o)
    else $error("wb_stb_o still high after wb_ack_i");

endmodule

bind ldst_arbiter streamer_sva u_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .wb_cyc_o (wb_cyc_o),
  .wb_stb_o (wb_stb_o),
  .wb_we_o  (wb_we_o),
  .wb_adr_o (wb_adr_o),
  .wb_dat_o (wb_dat_o),
  .wb_ack_i (wb_ack_i)
);

`default_nettype wire

// File: tests/streamer_tb.sv
// Streamer testbench with Wishbone memory model, stream drivers, reference casts and checker
`include "streamer_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module streamer_tb;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    cast_en_i;
  logic                    ld_start_i;
  logic [`STREAMER_AW-1:0] ld_base_i;
  logic [`STREAMER_LW-1:0] ld_words_i;
  logic                    st_start_i;
  logic [`STREAMER_AW-1:0] st_base_i;
  logic [`STREAMER_LW-1:0] st_words_i;
  logic                    x_ready_i;
  logic                    z_valid_i;
  logic [`STREAMER_DW-1:0] z_data_i;
  logic [`STREAMER_DW-1:0] wb_dat_i;
  logic                    wb_ack_i;
  logic                    x_valid_o;
  logic [`STREAMER_DW-1:0] x_data_o;
  logic                    z_ready_o;
  logic                    ld_busy_o;
  logic                    st_busy_o;
  logic                    ld_done_o;
  logic                    st_done_o;
  logic                    wb_cyc_o;
  logic                    wb_stb_o;
  logic                    wb_we_o;
  logic [`STREAMER_AW-1:0] wb_adr_o;
  logic [`STREAMER_DW/8-1:0] wb_sel_o;
  logic [`STREAMER_DW-1:0] wb_dat_o;

  // Memory model, 256 words at byte addresses 0x000 to 0x3fc
  logic [31:0] mem [256];
  logic [31:0] lfsr_q = 32'hd9d86b1e;
  // Memory transfer in progress and its remaining wait
  logic        xfer_on;
  int          ack_delay;
  // Z beat taken at the coming rising edge
  logic        z_hs_pend;
  // Random back-pressure on both streams
  logic        bp_en;
  logic [31:0] exp_x_q [$];
  logic [31:0] z_q [$];
  logic [31:0] st_beats_q [$];
  int          chk_cnt;
  int          err_cnt;
  int          ld_done_cnt;
  int          st_done_cnt;

  streamer_top dut0 (.*);

  initial begin
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic [31:0] fp16_to_fp32(input logic [15:0] h);
    logic [7:0] e8;
    e8 = {3'b000, h[14:10]} + 8'd112;
    if (h[14:10] == 5'd0) begin
      return {h[15], 31'd0};
    end
    if (h[14:10] == 5'd31) begin
      return {h[15], 8'hff, h[9:0], 13'd0};
    end
    return {h[15], e8, h[9:0], 13'd0};
  endfunction

  function automatic logic [15:0] fp32_to_fp16(input logic [31:0] w);
    logic [9:0] mk;
    int         rb;
    mk = w[22:13];
    rb = int'(w[30:23]) - 112;
    if (w[30:23] == 8'hff) begin
      // A NaN must not turn into infinity
      if (w[22:0] != 23'd0 && mk == 10'd0) begin
        mk[9] = 1'b1;
      end
      return {w[31], 5'h1f, mk};
    end
    if (rb <= 0) begin
      return {w[31], 15'd0};
    end
    if (rb >= 31) begin
      return {w[31], 5'h1f, 10'd0};
    end
    return {w[31], rb[4:0], mk};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    chk_cnt++;
    assert (ok === 1'b1) else begin
      $display("Failure: %s", what);
      err_cnt++;
    end
  endtask

  task automatic check_idle();
    check_cond(!wb_cyc_o && !wb_stb_o, "Wishbone cycle or strobe high while idle");
    check_cond(!x_valid_o && !z_ready_o, "x_valid_o or z_ready_o high while idle");
    check_cond(!ld_busy_o && !st_busy_o, "a busy output is high while idle");
    check_cond(!ld_done_o && !st_done_o, "a done output is high while idle");
  endtask

  // Both starts share cast_en_i
  task automatic start_jobs(input logic ld, input logic st, input logic cast,
                            input logic [31:0] ld_base, input logic [15:0] ld_words,
                            input logic [31:0] st_base, input logic [15:0] st_words);
    @(negedge clk_i);
    cast_en_i  = cast;
    ld_base_i  = ld_base;
    ld_words_i = ld_words;
    st_base_i  = st_base;
    st_words_i = st_words;
    ld_start_i = ld;
    st_start_i = st;
    @(negedge clk_i);
    ld_start_i = 1'b0;
    st_start_i = 1'b0;
  endtask

  task automatic wait_done(input logic store, input int target);
    int n;
    n = 0;
    while ((store ? st_done_cnt : ld_done_cnt) < target && n < 4000) begin
      @(negedge clk_i);
      n++;
    end
    check_cond((store ? st_done_cnt : ld_done_cnt) >= target,
               store ? "store done pulse did not arrive in time"
                     : "load done pulse did not arrive in time");
  endtask

  // Expected X beats straight from the memory words
  task automatic expect_load(input int idx, input int n, input logic cast);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      w = mem[idx + i];
      if (cast) begin
        exp_x_q.push_back(fp16_to_fp32(w[15:0]));
        exp_x_q.push_back(fp16_to_fp32(w[31:16]));
      end else begin
        exp_x_q.push_back(w);
      end
    end
  endtask

  task automatic add_beat(input logic [31:0] b);
    z_q.push_back(b);
    st_beats_q.push_back(b);
  endtask

  task automatic check_store(input int idx, input logic cast);
    logic [31:0] lo;
    logic [31:0] hi;
    int          k;
    k = 0;
    while (st_beats_q.size() != 0) begin
      lo = st_beats_q.pop_front();
      if (cast) begin
        hi = st_beats_q.pop_front();
        check_value($sformatf("mem[%0d]", idx + k), mem[idx + k],
                    {fp32_to_fp16(hi), fp32_to_fp16(lo)});
      end else begin
        check_value($sformatf("mem[%0d]", idx + k), mem[idx + k], lo);
      end
      k++;
    end
  endtask

  // Memory answers and stream drivers, all on the falling edge
  always @(negedge clk_i) begin
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
      xfer_on  = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!xfer_on) begin
        xfer_on   = 1'b1;
        ack_delay = rand_bits(2);
        // Every transfer enables all four byte lanes
        check_value("wb_sel_o", wb_sel_o, 32'h0000000f);
      end
      if (ack_delay == 0) begin
        if (wb_we_o) begin
          mem[wb_adr_o[9:2]] = wb_dat_o;
        end else begin
          wb_dat_i = mem[wb_adr_o[9:2]];
        end
        wb_ack_i = 1'b1;
      end else begin
        ack_delay--;
      end
    end
    x_ready_i = bp_en ? (rand_bits(1) != 0) : 1'b1;
    // Valid stays up with the same beat until it is taken
    if (z_hs_pend) begin
      void'(z_q.pop_front());
    end
    if (z_q.size() == 0) begin
      z_valid_i = 1'b0;
    end else if (!z_valid_i || z_hs_pend) begin
      z_valid_i = bp_en ? (rand_bits(1) != 0) : 1'b1;
    end
    z_data_i  = (z_q.size() != 0) ? z_q[0] : '0;
    z_hs_pend = z_valid_i && z_ready_o;
  end

  // Comparing process for X beats and done pulses
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (x_valid_o && x_ready_i) begin
        check_cond(exp_x_q.size() != 0, "X beat arrived with no beat expected");
        if (exp_x_q.size() != 0) begin
          check_value("x_data_o", x_data_o, exp_x_q.pop_front());
        end
      end
      if (ld_done_o) begin
        ld_done_cnt++;
      end
      if (st_done_o) begin
        st_done_cnt++;
      end
    end
  end

  initial begin
    rst_n_i     = 1'b0;
    cast_en_i   = 1'b0;
    ld_start_i  = 1'b0;
    ld_base_i   = '0;
    ld_words_i  = '0;
    st_start_i  = 1'b0;
    st_base_i   = '0;
    st_words_i  = '0;
    x_ready_i   = 1'b0;
    z_valid_i   = 1'b0;
    z_data_i    = '0;
    wb_dat_i    = '0;
    wb_ack_i    = 1'b0;
    xfer_on     = 1'b0;
    ack_delay   = 0;
    z_hs_pend   = 1'b0;
    bp_en       = 1'b0;
    chk_cnt     = 0;
    err_cnt     = 0;
    ld_done_cnt = 0;
    st_done_cnt = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = rand_bits(32);
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle();

    // Plain load of eight words
    @(posedge clk_i);
    expect_load(0, 8, 1'b0);
    start_jobs(1'b1, 1'b0, 1'b0, 32'h000, 16'd8, 32'h0, 16'd0);
    wait_done(1'b0, 1);
    repeat (3) @(negedge clk_i);
    check_value("ld_done count", ld_done_cnt, 1);
    check_cond(exp_x_q.size() == 0, "plain load left X beats missing");
    check_idle();

    // Widening load, zero, denormal, infinity and NaN halves first
    @(posedge clk_i);
    mem[16] = {16'h8000, 16'h0000};
    mem[17] = {16'h7c00, 16'h0201};
    mem[18] = {16'h7e01, 16'hfc00};
    for (int i = 19; i < 22; i++) begin
      mem[i] = rand_bits(32);
    end
    expect_load(16, 6, 1'b1);
    start_jobs(1'b1, 1'b0, 1'b1, 32'h040, 16'd6, 32'h0, 16'd0);
    wait_done(1'b0, 2);
    repeat (3) @(negedge clk_i);
    check_value("ld_done count", ld_done_cnt, 2);
    check_cond(exp_x_q.size() == 0, "widening load left X beats missing");

    // Plain store of eight random beats
    @(posedge clk_i);
    for (int i = 0; i < 8; i++) begin
      add_beat(rand_bits(32));
    end
    start_jobs(1'b0, 1'b1, 1'b0, 32'h0, 16'd0, 32'h200, 16'd8);
    wait_done(1'b1, 1);
    repeat (3) @(negedge clk_i);
    check_value("st_done count", st_done_cnt, 1);
    check_store(128, 1'b0);
    check_idle();

    // Narrowing store with overflow, underflow, NaN and infinity beats
    @(posedge clk_i);
    add_beat(32'h47800000);
    add_beat(32'hc7800000);
    add_beat(32'h33800000);
    add_beat(32'h38800000);
    add_beat(32'h7fc00000);
    add_beat(32'h7f800001);
    add_beat(32'hff800000);
    for (int i = 0; i < 3; i++) begin
      add_beat(rand_bits(32));
    end
    start_jobs(1'b0, 1'b1, 1'b1, 32'h0, 16'd0, 32'h240, 16'd5);
    wait_done(1'b1, 2);
    repeat (3) @(negedge clk_i);
    check_value("st_done count", st_done_cnt, 2);
    check_store(144, 1'b1);

    // Both channels together under back-pressure
    @(posedge clk_i);
    bp_en = 1'b1;
    expect_load(32, 10, 1'b1);
    for (int i = 0; i < 8; i++) begin
      add_beat(rand_bits(32));
    end
    start_jobs(1'b1, 1'b1, 1'b1, 32'h080, 16'd10, 32'h300, 16'd4);
    wait_done(1'b0, 3);
    wait_done(1'b1, 3);
    repeat (3) @(negedge clk_i);
    check_value("ld_done count", ld_done_cnt, 3);
    check_value("st_done count", st_done_cnt, 3);
    check_cond(exp_x_q.size() == 0, "shared run left X beats missing");
    check_store(192, 1'b1);
    check_idle();

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/streamer_pkg.sv
load/cast_in.sv
load/load_channel.sv
store/cast_out.sv
store/store_channel.sv
rtl/ldst_arbiter.sv
rtl/streamer_top.sv
tests/streamer_sva.sv
tests/streamer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := streamer_tb
FLIST     := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))
HDRS      := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
